// ==== all.f ====
rtl/pipe_ctrl_pkg.sv
rtl/data_hazard.sv
rtl/pipe_control.sv
rtl/stage_track.sv
rtl/pipe_ctrl_top.sv
tb/tb_clock.sv
tb/tb_pipe_ctrl.sv

// ==== Makefile ====
TOP := tb_pipe_ctrl

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --top-module $(TOP) -f all.f -Mdir obj_dir -o sim
	./obj_dir/sim | tee sim.log
	@grep -qx "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb/tb_pipe_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_pipe_ctrl
    import pipe_ctrl_pkg::*;
();

    localparam int clk_period = 10;
    localparam int rst_cycles = 10;
    localparam int max_rows   = 32;

    // ID flag bits of a table row
    localparam int fv = 1, fw = 2, fld = 4, fbr = 8;
    localparam int fj = 16, fmret = 32, fecall = 64, ffi = 128;

    logic clk, rst_n;
    logic id_valid, id_r_wen, id_mem_ren, id_branch, id_jump, id_mret, id_ecall, id_fence_i;
    logic [reg_addr_w-1:0] id_rs1, id_rs2, id_rd;
    logic [xlen-1:0] id_pc, id_imm, id_rs1_value, id_rs2_value;
    logic [xlen-1:0] ex_result, mem_rdata, mtvec, mepc;
    logic [xlen-1:0] ex_rs1, ex_rs2, dnpc, wb_value;
    logic stall, dnpc_flag, inst_clear, icache_clr, wb_valid;
    logic [reg_addr_w-1:0] wb_rd;

    // Stimulus columns
    int st_flags [max_rows], st_rs1 [max_rows], st_rs2 [max_rows], st_rd [max_rows];
    logic [xlen-1:0] st_pc [max_rows], st_imm [max_rows], st_rs1v [max_rows], st_rs2v [max_rows];
    logic [xlen-1:0] st_exres [max_rows], st_mrdata [max_rows];
    logic [xlen-1:0] st_mtvec [max_rows], st_mepc [max_rows];
    // Expected columns
    logic [xlen-1:0] exp_rs1 [max_rows], exp_rs2 [max_rows], exp_dnpc [max_rows];
    logic [xlen-1:0] exp_wbval [max_rows];
    int exp_stall [max_rows], exp_flag [max_rows], exp_icclr [max_rows];
    int exp_wbv [max_rows], exp_wbrd [max_rows];

    int row_count = 0;
    int cur_row = 0;
    int n_checks = 0;
    int n_errors = 0;

    tb_clock clock0 (.clk(clk));

    pipe_ctrl_top dut0 (
        .clk(clk), .rst_n(rst_n),
        .id_valid(id_valid), .id_pc(id_pc), .id_imm(id_imm), .id_rs1(id_rs1),
        .id_rs2(id_rs2), .id_rd(id_rd), .id_r_wen(id_r_wen), .id_mem_ren(id_mem_ren),
        .id_branch(id_branch), .id_jump(id_jump), .id_mret(id_mret), .id_ecall(id_ecall),
        .id_fence_i(id_fence_i), .id_rs1_value(id_rs1_value), .id_rs2_value(id_rs2_value),
        .ex_result(ex_result), .mem_rdata(mem_rdata), .mtvec(mtvec), .mepc(mepc),
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .stall(stall), .dnpc(dnpc), .dnpc_flag(dnpc_flag),
        .inst_clear(inst_clear), .icache_clr(icache_clr), .wb_valid(wb_valid),
        .wb_rd(wb_rd), .wb_value(wb_value)
    );

    task automatic add_stim(input int flags, input int rs1, input int rs2, input int rd,
                            input logic [xlen-1:0] pc, input logic [xlen-1:0] imm,
                            input logic [xlen-1:0] rs1v, input logic [xlen-1:0] rs2v,
                            input logic [xlen-1:0] exres, input logic [xlen-1:0] mrdata,
                            input logic [xlen-1:0] tvec, input logic [xlen-1:0] epc);
        st_flags[row_count] = flags;
        st_rs1[row_count]   = rs1;
        st_rs2[row_count]   = rs2;
        st_rd[row_count]    = rd;
        st_pc[row_count]    = pc;
        st_imm[row_count]   = imm;
        st_rs1v[row_count]  = rs1v;
        st_rs2v[row_count]  = rs2v;
        st_exres[row_count] = exres;
        st_mrdata[row_count] = mrdata;
        st_mtvec[row_count] = tvec;
        st_mepc[row_count]  = epc;
    endtask

    // Closes the row opened by add_stim
    task automatic expect_row(input logic [xlen-1:0] rs1, input logic [xlen-1:0] rs2,
                              input int stl, input int flag, input logic [xlen-1:0] npc,
                              input int icclr, input int wbv, input int wbrd,
                              input logic [xlen-1:0] wbval);
        exp_rs1[row_count]   = rs1;
        exp_rs2[row_count]   = rs2;
        exp_stall[row_count] = stl;
        exp_flag[row_count]  = flag;
        exp_dnpc[row_count]  = npc;
        exp_icclr[row_count] = icclr;
        exp_wbv[row_count]   = wbv;
        exp_wbrd[row_count]  = wbrd;
        exp_wbval[row_count] = wbval;
        row_count++;
    endtask

    task automatic fill_table();
        // Idle row right after reset
        add_stim(0, 0, 0, 0, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0, 'h800, 'h900);
        expect_row('h0, 'h0, 0, 0, 'h0, 0, 0, 0, 'h0);
        // Three writers of x5, then readers
        add_stim(fv|fw, 0, 0, 5, 'h100, 'h0, 'h11, 'h22, 'h0, 'h0, 'h800, 'h900);
        expect_row('h11, 'h22, 0, 0, 'h0, 0, 0, 0, 'h0);
        add_stim(fv|fw, 0, 0, 5, 'h104, 'h0, 'h11, 'h22, 'hA1, 'h0, 'h800, 'h900);
        expect_row('h11, 'h22, 0, 0, 'h0, 0, 0, 0, 'h0);
        add_stim(fv|fw, 0, 0, 5, 'h108, 'h0, 'h11, 'h22, 'hB2, 'h0, 'h800, 'h900);
        expect_row('h11, 'h22, 0, 0, 'h0, 0, 0, 0, 'h0);
        add_stim(fv, 5, 0, 0, 'h10C, 'h0, 'h11, 'h22, 'hC3, 'h0, 'h800, 'h900);
        expect_row('hC3, 'h22, 0, 0, 'h0, 0, 1, 5, 'hA1);          // EX wins
        add_stim(fv, 5, 0, 0, 'h110, 'h0, 'h11, 'h22, 'hD4, 'h0, 'h800, 'h900);
        expect_row('hC3, 'h22, 0, 0, 'h0, 0, 1, 5, 'hB2);          // MEM ALU result
        add_stim(fv|fw, 5, 0, 0, 'h114, 'h0, 'h11, 'h22, 'hE5, 'h0, 'h800, 'h900);
        expect_row('hC3, 'h22, 0, 0, 'h0, 0, 1, 5, 'hC3);          // WB value
        add_stim(fv, 0, 0, 0, 'h118, 'h0, 'h77, 'h88, 'hF6, 'h0, 'h800, 'h900);
        expect_row('h77, 'h88, 0, 0, 'h0, 0, 1, 0, 'hD4);          // x0 ignores writers
        // Load of x7 and a dependent reader
        add_stim(fv|fw|fld, 0, 0, 7, 'h200, 'h0, 'h11, 'h22, 'h70, 'h0, 'h800, 'h900);
        expect_row('h11, 'h22, 0, 0, 'h0, 0, 1, 0, 'hE5);
        add_stim(fv|fw, 0, 7, 8, 'h204, 'h0, 'h11, 'h22, 'h3000, 'h0, 'h800, 'h900);
        expect_row('h11, 'h3000, 1, 0, 'h0, 0, 1, 0, 'hF6);
        add_stim(fv|fw, 0, 7, 8, 'h204, 'h0, 'h11, 'h22, 'h0, 'hCAFE0007, 'h800, 'h900);
        expect_row('h11, 'hCAFE0007, 0, 0, 'h0, 0, 1, 0, 'h70);
        add_stim(fv, 0, 0, 0, 'h208, 'h0, 'h11, 'h22, 'h88, 'h0, 'h800, 'h900);
        expect_row('h11, 'h22, 0, 0, 'h0, 0, 1, 7, 'hCAFE0007);
        // Taken branch, then a not-taken one
        add_stim(fv|fbr, 0, 0, 0, 'h300, 'h40, 'h11, 'h22, 'h0, 'h0, 'h800, 'h900);
        expect_row('h11, 'h22, 0, 0, 'h0, 0, 0, 0, 'h0);
        add_stim(fv|fw, 0, 0, 9, 'h304, 'h0, 'h11, 'h22, 'h1, 'h0, 'h800, 'h900);
        expect_row('h11, 'h22, 0, 1, 'h340, 0, 1, 8, 'h88);
        add_stim(fv|fbr, 0, 0, 0, 'h340, 'h80, 'h11, 'h22, 'h0, 'h0, 'h800, 'h900);
        expect_row('h11, 'h22, 0, 0, 'h0, 0, 1, 0, 'h0);
        add_stim(fv|fw, 0, 0, 10, 'h344, 'h0, 'h11, 'h22, 'h2, 'h0, 'h800, 'h900);
        expect_row('h11, 'h22, 0, 0, 'h0, 0, 1, 0, 'h1);
        // Jump; the cleared x9 writer leaves a hole in WB here
        add_stim(fv|fw|fj, 0, 0, 1, 'h348, 'h0, 'h11, 'h22, 'hA10, 'h0, 'h800, 'h900);
        expect_row('h11, 'h22, 0, 0, 'h0, 0, 0, 0, 'h0);
        add_stim(fv|fw, 0, 0, 11, 'h34C, 'h0, 'h11, 'h22, 'h500, 'h0, 'h800, 'h900);
        expect_row('h11, 'h22, 0, 1, 'h500, 0, 1, 0, 'h2);
        // fence.i refetches the next pc
        add_stim(fv|ffi, 0, 0, 0, 'h500, 'h0, 'h11, 'h22, 'h0, 'h0, 'h800, 'h900);
        expect_row('h11, 'h22, 0, 0, 'h0, 0, 1, 10, 'hA10);
        add_stim(fv|fw, 0, 0, 12, 'h504, 'h0, 'h11, 'h22, 'h0, 'h0, 'h800, 'h900);
        expect_row('h11, 'h22, 0, 1, 'h504, 1, 1, 1, 'h500);
        // Trap entry and return from ID
        add_stim(fv|fmret, 0, 0, 0, 'h508, 'h0, 'h11, 'h22, 'h0, 'h0, 'h800, 'h900);
        expect_row('h11, 'h22, 0, 1, 'h900, 0, 0, 0, 'h0);
        add_stim(fv|fecall, 0, 0, 0, 'h50C, 'h0, 'h11, 'h22, 'h0, 'h0, 'h800, 'h900);
        expect_row('h11, 'h22, 0, 1, 'h800, 0, 1, 0, 'h0);
        // EX jump against ID ecall
        add_stim(fv|fj, 0, 0, 0, 'h600, 'h0, 'h11, 'h22, 'h0, 'h0, 'h800, 'h900);
        expect_row('h11, 'h22, 0, 0, 'h0, 0, 0, 0, 'h0);
        add_stim(fv|fecall, 0, 0, 0, 'h604, 'h0, 'h11, 'h22, 'h700, 'h0, 'h800, 'h900);
        expect_row('h11, 'h22, 0, 1, 'h700, 0, 0, 0, 'h0);
        add_stim(0, 0, 0, 0, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0, 'h800, 'h900);
        expect_row('h0, 'h0, 0, 0, 'h0, 0, 0, 0, 'h0);
        add_stim(0, 0, 0, 0, 'h0, 'h0, 'h0, 'h0, 'h0, 'h0, 'h800, 'h900);
        expect_row('h0, 'h0, 0, 0, 'h0, 0, 1, 0, 'h700);
    endtask

    task automatic apply_row(input int i);
        id_valid     = st_flags[i][0];
        id_r_wen     = st_flags[i][1];
        id_mem_ren   = st_flags[i][2];
        id_branch    = st_flags[i][3];
        id_jump      = st_flags[i][4];
        id_mret      = st_flags[i][5];
        id_ecall     = st_flags[i][6];
        id_fence_i   = st_flags[i][7];
        id_rs1       = st_rs1[i][reg_addr_w-1:0];
        id_rs2       = st_rs2[i][reg_addr_w-1:0];
        id_rd        = st_rd[i][reg_addr_w-1:0];
        id_pc        = st_pc[i];
        id_imm       = st_imm[i];
        id_rs1_value = st_rs1v[i];
        id_rs2_value = st_rs2v[i];
        ex_result    = st_exres[i];
        mem_rdata    = st_mrdata[i];
        mtvec        = st_mtvec[i];
        mepc         = st_mepc[i];
    endtask

    task automatic check_word(input string name, input logic [xlen-1:0] exp,
                              input logic [xlen-1:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t row %0d: %s expected %h, got %h",
                     $time, cur_row, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t row %0d: %s expected %b, got %b",
                     $time, cur_row, name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input logic [reg_addr_w-1:0] exp,
                             input logic [reg_addr_w-1:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("MISMATCH at %0t row %0d: %s expected x%0d, got x%0d",
                     $time, cur_row, name, exp, act);
        end
    endtask

    task automatic check_row(input int i);
        check_word("ex_rs1", exp_rs1[i], ex_rs1);
        check_word("ex_rs2", exp_rs2[i], ex_rs2);
        check_bit("stall", exp_stall[i][0], stall);
        check_bit("dnpc_flag", exp_flag[i][0], dnpc_flag);
        check_bit("inst_clear", exp_flag[i][0], inst_clear);
        check_word("dnpc", exp_dnpc[i], dnpc);
        check_bit("icache_clr", exp_icclr[i][0], icache_clr);
        check_bit("wb_valid", exp_wbv[i][0], wb_valid);
        if (exp_wbv[i] != 0) begin     // WB payload means nothing without valid
            check_reg("wb_rd", exp_wbrd[i][reg_addr_w-1:0], wb_rd);
            check_word("wb_value", exp_wbval[i], wb_value);
        end
    endtask

    initial begin
        rst_n = 1'b0;
        fill_table();
        apply_row(0);
        // Writer held in ID through reset, it must not reach WB
        id_valid = 1'b1;
        id_r_wen = 1'b1;
        id_rd    = 5'd5;
        repeat (rst_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int i = 0; i < row_count; i++) begin
            cur_row = i;
            apply_row(i);
            #(clk_period / 2 - 1);      // Just before the rising edge
            check_row(i);
            @(negedge clk);
        end
        $display("Rows %0d, checks %0d, mismatches %0d", row_count, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog sized from reset plus table length
    initial begin
        #1;
        #((rst_cycles + row_count + 10) * clk_period);
        $display("Timeout: the table did not finish within %0d cycles",
                 rst_cycles + row_count + 10);
        $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    initial clk = 1'b0;

    always #5 clk = ~clk;   // 10 ns period

endmodule

`default_nettype wire

// ==== rtl/pipe_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl_top
    import pipe_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  id_valid,
    input  logic [xlen-1:0]       id_pc,
    input  logic [xlen-1:0]       id_imm,
    input  logic [reg_addr_w-1:0] id_rs1,
    input  logic [reg_addr_w-1:0] id_rs2,
    input  logic [reg_addr_w-1:0] id_rd,
    input  logic                  id_r_wen,
    input  logic                  id_mem_ren,
    input  logic                  id_branch,
    input  logic                  id_jump,
    input  logic                  id_mret,
    input  logic                  id_ecall,
    input  logic                  id_fence_i,
    input  logic [xlen-1:0]       id_rs1_value,
    input  logic [xlen-1:0]       id_rs2_value,

    input  logic [xlen-1:0]       ex_result,
    input  logic [xlen-1:0]       mem_rdata,
    input  logic [xlen-1:0]       mtvec,
    input  logic [xlen-1:0]       mepc,

    output logic [xlen-1:0]       ex_rs1,
    output logic [xlen-1:0]       ex_rs2,
    output logic                  stall,
    output logic [xlen-1:0]       dnpc,
    output logic                  dnpc_flag,
    output logic                  inst_clear,
    output logic                  icache_clr,
    output logic                  wb_valid,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic [xlen-1:0]       wb_value
);

    // Stage state between the trackers and the control
    logic                  ex_valid, mem_valid;
    logic [reg_addr_w-1:0] ex_rd, mem_rd;
    logic                  ex_r_wen, mem_r_wen, wb_r_wen;
    logic                  ex_mem_ren, mem_mem_ren;
    logic [xlen-1:0]       ex_pc, ex_imm, mem_ex_result;
    logic                  ex_jump, ex_branch, ex_fence_i;

    stage_track u_stage_track (
        .clk(clk), .rst_n(rst_n),
        .id_valid(id_valid), .id_pc(id_pc), .id_imm(id_imm), .id_rd(id_rd),
        .id_r_wen(id_r_wen), .id_mem_ren(id_mem_ren), .id_branch(id_branch),
        .id_jump(id_jump), .id_fence_i(id_fence_i), .id_mret(id_mret),
        .id_ecall(id_ecall), .ex_result(ex_result), .mem_rdata(mem_rdata),
        .stall(stall), .inst_clear(inst_clear),
        .ex_valid(ex_valid), .ex_rd(ex_rd), .ex_r_wen(ex_r_wen),
        .ex_mem_ren(ex_mem_ren), .ex_pc(ex_pc), .ex_imm(ex_imm),
        .ex_jump(ex_jump), .ex_branch(ex_branch), .ex_fence_i(ex_fence_i),
        .mem_valid(mem_valid), .mem_rd(mem_rd), .mem_r_wen(mem_r_wen),
        .mem_mem_ren(mem_mem_ren), .mem_ex_result(mem_ex_result),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_r_wen(wb_r_wen),
        .wb_rd_value(wb_value)          // Write-back value is also the forwarding source
    );

    pipe_control u_pipe_control (
        .mtvec(mtvec), .mepc(mepc), .ex_pc(ex_pc), .ex_imm(ex_imm),
        .ex_result(ex_result), .mem_ex_result(mem_ex_result),
        .mem_rdata(mem_rdata), .wb_rd_value(wb_value),
        .id_rs1_value(id_rs1_value), .id_rs2_value(id_rs2_value),
        .id_mret(id_mret), .id_ecall(id_ecall), .ex_branch(ex_branch),
        .ex_jump(ex_jump), .ex_fence_i(ex_fence_i),
        .id_valid(id_valid), .id_rs1(id_rs1), .id_rs2(id_rs2),
        .ex_valid(ex_valid), .mem_valid(mem_valid), .wb_valid(wb_valid),
        .ex_rd(ex_rd), .mem_rd(mem_rd), .wb_rd(wb_rd),
        .ex_r_wen(ex_r_wen), .mem_r_wen(mem_r_wen), .wb_r_wen(wb_r_wen),
        .ex_mem_ren(ex_mem_ren), .mem_mem_ren(mem_mem_ren),
        .ex_rs1(ex_rs1), .ex_rs2(ex_rs2), .stall(stall),
        .inst_clear(inst_clear), .icache_clr(icache_clr),
        .dnpc(dnpc), .dnpc_flag(dnpc_flag)
    );

endmodule

`default_nettype wire

// ==== rtl/stage_track.sv ====
`timescale 1ns/1ps
`default_nettype none

module stage_track
    import pipe_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  id_valid,
    input  logic [xlen-1:0]       id_pc,
    input  logic [xlen-1:0]       id_imm,
    input  logic [reg_addr_w-1:0] id_rd,
    input  logic                  id_r_wen,
    input  logic                  id_mem_ren,
    input  logic                  id_branch,
    input  logic                  id_jump,
    input  logic                  id_fence_i,
    input  logic                  id_mret,
    input  logic                  id_ecall,

    input  logic [xlen-1:0]       ex_result,
    input  logic [xlen-1:0]       mem_rdata,
    input  logic                  stall,
    input  logic                  inst_clear,

    output logic                  ex_valid,
    output logic [reg_addr_w-1:0] ex_rd,
    output logic                  ex_r_wen,
    output logic                  ex_mem_ren,
    output logic [xlen-1:0]       ex_pc,
    output logic [xlen-1:0]       ex_imm,
    output logic                  ex_jump,
    output logic                  ex_branch,
    output logic                  ex_fence_i,

    output logic                  mem_valid,
    output logic [reg_addr_w-1:0] mem_rd,
    output logic                  mem_r_wen,
    output logic                  mem_mem_ren,
    output logic [xlen-1:0]       mem_ex_result,

    output logic                  wb_valid,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic                  wb_r_wen,
    output logic [xlen-1:0]       wb_rd_value
);

    logic id_take;

    // mret and ecall redirect from ID and never enter EX
    assign id_take = id_valid && !stall && !inst_clear && !id_mret && !id_ecall;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_valid    <= 1'b0;
            ex_r_wen    <= 1'b0;
            ex_mem_ren  <= 1'b0;
            ex_jump     <= 1'b0;
            ex_branch   <= 1'b0;
            ex_fence_i  <= 1'b0;
            mem_valid   <= 1'b0;
            mem_r_wen   <= 1'b0;
            mem_mem_ren <= 1'b0;
            wb_valid    <= 1'b0;
            wb_r_wen    <= 1'b0;
        end else begin
            // Bubble clears every flag, not just valid
            ex_valid    <= id_take;
            ex_r_wen    <= id_take && id_r_wen;
            ex_mem_ren  <= id_take && id_mem_ren;
            ex_jump     <= id_take && id_jump;
            ex_branch   <= id_take && id_branch;
            ex_fence_i  <= id_take && id_fence_i;

            mem_valid   <= ex_valid;
            mem_r_wen   <= ex_r_wen;
            mem_mem_ren <= ex_mem_ren;

            wb_valid    <= mem_valid;
            wb_r_wen    <= mem_r_wen;
        end
    end

    // Payload follows the flags
    always_ff @(posedge clk) begin
        ex_rd         <= id_rd;
        ex_pc         <= id_pc;
        ex_imm        <= id_imm;

        mem_rd        <= ex_rd;
        mem_ex_result <= ex_result;     // ALU output captured on leaving EX

        wb_rd         <= mem_rd;
        wb_rd_value   <= mem_mem_ren ? mem_rdata : mem_ex_result;
    end

endmodule

`default_nettype wire

// ==== rtl/pipe_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_control
    import pipe_ctrl_pkg::*;
(
    input  logic [xlen-1:0]       mtvec,
    input  logic [xlen-1:0]       mepc,
    input  logic [xlen-1:0]       ex_pc,
    input  logic [xlen-1:0]       ex_imm,
    input  logic [xlen-1:0]       ex_result,      // Bit 0 doubles as branch condition
    input  logic [xlen-1:0]       mem_ex_result,
    input  logic [xlen-1:0]       mem_rdata,
    input  logic [xlen-1:0]       wb_rd_value,
    input  logic [xlen-1:0]       id_rs1_value,
    input  logic [xlen-1:0]       id_rs2_value,

    input  logic                  id_mret,
    input  logic                  id_ecall,
    input  logic                  ex_branch,
    input  logic                  ex_jump,
    input  logic                  ex_fence_i,

    input  logic                  id_valid,
    input  logic [reg_addr_w-1:0] id_rs1,
    input  logic [reg_addr_w-1:0] id_rs2,
    input  logic                  ex_valid,
    input  logic                  mem_valid,
    input  logic                  wb_valid,
    input  logic [reg_addr_w-1:0] ex_rd,
    input  logic [reg_addr_w-1:0] mem_rd,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic                  ex_r_wen,
    input  logic                  mem_r_wen,
    input  logic                  wb_r_wen,
    input  logic                  ex_mem_ren,
    input  logic                  mem_mem_ren,

    output logic [xlen-1:0]       ex_rs1,
    output logic [xlen-1:0]       ex_rs2,
    output logic                  stall,
    output logic                  inst_clear,
    output logic                  icache_clr,
    output logic [xlen-1:0]       dnpc,
    output logic                  dnpc_flag
);

    logic [fwd_sel_w-1:0] rs1_sel;
    logic [fwd_sel_w-1:0] rs2_sel;
    logic                 ex_taken;
    logic                 ex_jump_v;
    logic                 ex_fence_v;

    function automatic logic [xlen-1:0] fwd_mux(input logic [fwd_sel_w-1:0] sel,
                                                input logic [xlen-1:0] reg_value);
        case (sel)
            fwd_ex:       return ex_result;
            fwd_wb:       return wb_rd_value;
            fwd_mem_load: return mem_rdata;
            fwd_mem_alu:  return mem_ex_result;
            default:      return reg_value;
        endcase
    endfunction

    data_hazard u_data_hazard (
        .id_valid    (id_valid),
        .id_rs1      (id_rs1),
        .id_rs2      (id_rs2),
        .ex_valid    (ex_valid),
        .mem_valid   (mem_valid),
        .wb_valid    (wb_valid),
        .ex_rd       (ex_rd),
        .mem_rd      (mem_rd),
        .wb_rd       (wb_rd),
        .ex_r_wen    (ex_r_wen),
        .mem_r_wen   (mem_r_wen),
        .wb_r_wen    (wb_r_wen),
        .ex_mem_ren  (ex_mem_ren),
        .mem_mem_ren (mem_mem_ren),
        .rs1_sel     (rs1_sel),
        .rs2_sel     (rs2_sel),
        .stall       (stall)
    );

    always_comb begin
        ex_rs1 = fwd_mux(rs1_sel, id_rs1_value);
        ex_rs2 = fwd_mux(rs2_sel, id_rs2_value);
    end

    assign ex_jump_v  = ex_valid && ex_jump;
    assign ex_taken   = ex_valid && ex_branch && ex_result[0];
    assign ex_fence_v = ex_valid && ex_fence_i;

    // EX redirects are older than ID, so they come first
    always_comb begin
        dnpc_flag = 1'b1;
        if (ex_jump_v)                  dnpc = ex_result;
        else if (ex_taken)              dnpc = ex_pc + ex_imm;
        else if (ex_fence_v)            dnpc = ex_pc + pc_step; // Refetch after fence.i
        else if (id_valid && id_mret)   dnpc = mepc;
        else if (id_valid && id_ecall)  dnpc = mtvec;
        else begin
            dnpc      = '0;
            dnpc_flag = 1'b0;
        end
    end

    assign inst_clear = dnpc_flag;      // Younger ID instruction is dropped
    assign icache_clr = ex_fence_v;

endmodule

`default_nettype wire

// ==== rtl/data_hazard.sv ====
`timescale 1ns/1ps
`default_nettype none

module data_hazard
    import pipe_ctrl_pkg::*;
(
    input  logic                  id_valid,
    input  logic [reg_addr_w-1:0] id_rs1,
    input  logic [reg_addr_w-1:0] id_rs2,

    input  logic                  ex_valid,
    input  logic                  mem_valid,
    input  logic                  wb_valid,

    input  logic [reg_addr_w-1:0] ex_rd,
    input  logic [reg_addr_w-1:0] mem_rd,
    input  logic [reg_addr_w-1:0] wb_rd,

    input  logic                  ex_r_wen,
    input  logic                  mem_r_wen,
    input  logic                  wb_r_wen,
    input  logic                  ex_mem_ren,
    input  logic                  mem_mem_ren,

    output logic [fwd_sel_w-1:0]  rs1_sel,
    output logic [fwd_sel_w-1:0]  rs2_sel,
    output logic                  stall
);

    // A stage supplies rs only if it really writes a nonzero rd
    function automatic logic writes(input logic valid, input logic wen,
                                    input logic [reg_addr_w-1:0] rd,
                                    input logic [reg_addr_w-1:0] rs);
        return valid && wen && (rd != '0) && (rd == rs);
    endfunction

    // Youngest writer wins
    function automatic logic [fwd_sel_w-1:0] pick(input logic [reg_addr_w-1:0] rs);
        if (writes(ex_valid, ex_r_wen, ex_rd, rs)) begin
            return fwd_ex;
        end else if (writes(mem_valid, mem_r_wen, mem_rd, rs)) begin
            return mem_mem_ren ? fwd_mem_load : fwd_mem_alu;
        end else if (writes(wb_valid, wb_r_wen, wb_rd, rs)) begin
            return fwd_wb;
        end
        return fwd_reg;
    endfunction

    logic ex_hit_rs1;
    logic ex_hit_rs2;

    always_comb begin
        rs1_sel = pick(id_rs1);
        rs2_sel = pick(id_rs2);
    end

    assign ex_hit_rs1 = writes(ex_valid, ex_r_wen, ex_rd, id_rs1);
    assign ex_hit_rs2 = writes(ex_valid, ex_r_wen, ex_rd, id_rs2);

    // Load in EX has no data until MEM so ID is held one cycle
    assign stall = id_valid && ex_mem_ren && (ex_hit_rs1 || ex_hit_rs2);

endmodule

`default_nettype wire

// ==== rtl/pipe_ctrl_pkg.sv ====
`default_nettype none

package pipe_ctrl_pkg;

    // Datapath and register file geometry
    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam int fwd_sel_w  = 3;      // Operand select width

    // Forwarding sources for an EX operand
    localparam logic [fwd_sel_w-1:0] fwd_reg      = 3'd0; // Register file read
    localparam logic [fwd_sel_w-1:0] fwd_ex       = 3'd1; // ALU result in EX
    localparam logic [fwd_sel_w-1:0] fwd_wb       = 3'd2; // Value being written back
    localparam logic [fwd_sel_w-1:0] fwd_mem_load = 3'd3; // Load data in MEM
    localparam logic [fwd_sel_w-1:0] fwd_mem_alu  = 3'd4; // ALU result carried in MEM

    // Sequential fetch step
    localparam logic [xlen-1:0] pc_step = 32'd4;

endpackage

`default_nettype wire
